/* mem_path.f */
common/mem_path_pkg.sv
design/bus_slot_sequencer.sv
design/reset_stretcher.sv
download/download_writer.sv
download/disk_image_detect.sv
memory/sdram_port_mux.sv
design/mem_path_top.sv
bench/mem_path_assertions.sv
bench/mem_path_checker.sv
bench/mem_path_tb.sv

/* Makefile */
# Verilator flow for the memory path testbench

VERILATOR ?= verilator
TOP       ?= mem_path_tb
FILELIST  ?= mem_path.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/mem_path_tb.sv */
// single clk32 domain; the sdram model answers reads in order and the loader is never stalled by it
`timescale 1ns/100ps

module mem_path_tb
	import mem_path_pkg::*;
();

	localparam int BUS_CYC     = SLOT_LEN * SLOTS_PER_CYCLE;   // clk32 cycles per bus cycle
	localparam int N_DL        = 8;                            // bytes per image index
	localparam int N_BP        = 16;
	localparam int N_DISK      = 8;
	localparam int N_RD        = 16;
	localparam int OPS         = 3 * N_DL + N_BP + N_DISK + N_RD + 5 * (RESET_HOLD / BUS_CYC);
	localparam longint WDOG_NS = longint'(OPS) * 20 * BUS_CYC * 10;

	logic        clk32;
	logic        rst_n;
	logic        load_active;
	logic [4:0]  load_index;
	logic [23:0] load_addr;
	logic [7:0]  load_data;
	logic        load_wr;
	logic        load_ready;
	logic [21:0] cpu_addr;
	logic        cpu_rom;
	logic        cpu_oe;
	logic        cpu_we;
	logic        cpu_uds;
	logic        cpu_lds;
	logic [15:0] cpu_wdata;
	logic        disk_read;
	logic        rd_valid;
	logic [15:0] rd_data;
	logic        mem_req;
	logic [24:0] mem_addr;
	logic        mem_we;
	logic [1:0]  mem_be;
	logic [15:0] mem_wdata;
	logic        mem_rvalid;
	logic [15:0] mem_rdata;
	logic        reset_req;
	logic        mem_size_sel;
	logic [1:0]  disk_eject;
	logic [1:0]  disk_inserted;
	logic [1:0]  disk_double_sided;
	logic        sys_reset_n;

	logic [31:0] lfsr;
	logic [1:0]  rd_q [$];   // {disk, odd} per read in flight
	int          req_cnt;
	int          ans_cnt;

	mem_path_top dut0 (.*);

	mem_path_checker chk0 (
		.clk32             (clk32),
		.rst_n             (rst_n),
		.slot              (dut0.slot),
		.load_ready        (load_ready),
		.mem_req           (mem_req),
		.mem_addr          (mem_addr),
		.mem_we            (mem_we),
		.mem_be            (mem_be),
		.mem_wdata         (mem_wdata),
		.rd_valid          (rd_valid),
		.rd_data           (rd_data),
		.disk_inserted     (disk_inserted),
		.disk_double_sided (disk_double_sided)
	);

	always #5 clk32 = ~clk32;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic void expected_request(input logic is_dl, input logic [4:0] idx,
		input logic [23:0] byte_addr, input logic [7:0] byte_val, input logic rom,
		input logic [1:0] strobes, output logic [24:0] addr, output logic [1:0] be,
		output logic [15:0] data);
		logic [20:0] offset;
		offset = (idx == IDX_DISK0) ? IMG_OFFSET_DISK0 :
			(idx == IDX_DISK1) ? IMG_OFFSET_DISK1 : 21'd0;
		if (is_dl) begin
			addr = {4'b0001, byte_addr[21:1] + offset};
			be   = byte_addr[0] ? 2'b01 : 2'b10;   // even byte in the upper lane
			data = {byte_val, byte_val};
		end else begin
			addr = {3'b000, rom, byte_addr[21:1]};
			be   = strobes;
			data = '0;
		end
	endfunction

	function automatic logic [15:0] expected_read(input logic [15:0] word, input logic disk,
		input logic odd, input logic loading);
		if (loading)
			return 16'hffff;
		if (disk)
			return odd ? {word[7:0], word[7:0]} : {word[15:8], word[15:8]};
		return word;
	endfunction

	// ------------------------------
	// sdram model
	// ------------------------------
	always @(posedge clk32)
		if (rst_n && mem_req && !mem_we)
			req_cnt <= req_cnt + 1;

	initial begin : sdram_model
		logic [15:0] word;
		logic [1:0]  fl;
		forever begin
			@(negedge clk32);
			if (req_cnt != ans_cnt) begin
				repeat (rand_bits(2)) @(negedge clk32);   // 0 to 3 extra cycles
				word       = 16'(rand_bits(16));
				fl         = rd_q.pop_front();
				mem_rdata  = word;
				mem_rvalid = 1'b1;
				chk0.expect_read(expected_read(word, fl[1], fl[0], load_active));
				ans_cnt++;
				@(negedge clk32);
				mem_rvalid = 1'b0;
			end
		end
	end

	// ------------------------------
	// stimulus tasks
	// ------------------------------
	task automatic load_byte(input logic [4:0] idx, input logic [23:0] addr,
		input logic [7:0] val);
		logic [24:0] a;
		logic [1:0]  be;
		logic [15:0] d;
		while (!load_ready)
			@(negedge clk32);
		load_index = idx;
		load_addr  = addr;
		load_data  = val;
		expected_request(1'b1, idx, addr, val, 1'b0, 2'b00, a, be, d);
		chk0.expect_request(a, 1'b1, be, d);
		load_wr = 1'b1;
		@(negedge clk32);
		load_wr = 1'b0;
		@(negedge clk32);
	endtask

	task automatic finish_download();
		while (!load_ready)
			@(negedge clk32);
		repeat (4) @(negedge clk32);   // let the last write reach the port
		load_active = 1'b0;
		repeat (2) @(negedge clk32);
	endtask

	task automatic load_disk(input logic [4:0] idx, input int last_word);
		load_active = 1'b1;
		load_index  = idx;
		load_addr   = {23'(last_word), 1'b1};   // last byte of the image
		repeat (2) @(negedge clk32);
		load_active = 1'b0;
		repeat (2) @(negedge clk32);
	endtask

	task automatic eject(input logic [1:0] mask);
		disk_eject = mask;
		@(negedge clk32);
		disk_eject = 2'b00;
		@(negedge clk32);
	endtask

	task automatic issue_read(input logic rom, input logic [21:0] addr, input logic disk,
		input logic [1:0] strobes);
		logic [24:0] a;
		logic [1:0]  be;
		logic [15:0] d;
		// line up with the cycle before a cpu slot starts
		while (!(dut0.slot_start && (dut0.slot == SLOT_VIDEO || dut0.slot == SLOT_IO)))
			@(negedge clk32);
		repeat (3) @(negedge clk32);
		cpu_rom   = rom;
		cpu_addr  = addr;
		disk_read = disk;
		{cpu_uds, cpu_lds} = strobes;
		cpu_oe    = 1'b1;
		expected_request(1'b0, 5'd0, {2'b00, addr}, 8'h00, rom, strobes, a, be, d);
		chk0.expect_request(a, 1'b0, be, d);
		rd_q.push_back({disk, addr[0]});
		repeat (2) @(negedge clk32);
		cpu_oe    = 1'b0;
		disk_read = 1'b0;
	endtask

	// source already removed at this negedge; count includes the last source cycle
	task automatic measure_release(input string what);
		int n;
		n = 1;
		do begin
			@(negedge clk32);
			n++;
		end while (!sys_reset_n);
		chk0.check_value(what, n, RESET_HOLD);
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin : main
		logic [1:0] strobes;
		clk32 = 1'b0;
		rst_n = 1'b0;
		lfsr  = 32'h51283da7;
		req_cnt = 0;
		ans_cnt = 0;
		{load_active, load_index, load_addr, load_data, load_wr} = '0;
		{cpu_addr, cpu_rom, cpu_oe, cpu_we, cpu_uds, cpu_lds, cpu_wdata, disk_read} = '0;
		{mem_rvalid, mem_rdata, reset_req, mem_size_sel, disk_eject} = '0;
		repeat (16) @(negedge clk32);
		rst_n = 1'b1;
		@(negedge clk32);

		for (int idx = 0; idx < 3; idx++) begin
			load_active = 1'b1;
			for (int i = 0; i < N_DL; i++)
				load_byte(5'(idx), 24'(rand_bits(20)), 8'(rand_bits(8)));
			finish_download();
		end
		chk0.end_test("download address mapping");

		load_active = 1'b1;
		for (int i = 0; i < N_BP; i++)
			load_byte(IDX_ROM, 24'(i), 8'(rand_bits(8)));
		finish_download();
		chk0.end_test("back-pressure");

		load_disk(IDX_DISK0, DISK_DS_LAST_WORD);
		load_disk(IDX_DISK1, DISK_SS_LAST_WORD);
		chk0.check_disk(2'b11, 2'b01);
		eject(2'b01);
		chk0.check_disk(2'b10, 2'b00);
		load_disk(IDX_DISK0, DISK_SS_LAST_WORD);
		load_disk(IDX_DISK1, DISK_DS_LAST_WORD);
		chk0.check_disk(2'b11, 2'b10);
		eject(2'b10);
		chk0.check_disk(2'b01, 2'b00);
		load_disk(IDX_DISK0, 12345);   // unknown size empties the drive
		chk0.check_disk(2'b00, 2'b00);
		chk0.end_test("disk size detection");

		load_index = 5'd3;   // no image behind index 3
		for (int i = 0; i < N_RD; i++) begin
			strobes = 2'(rand_bits(2));
			if (strobes == 2'b00)
				strobes = 2'b11;
			load_active = (i % 4 == 3);
			issue_read(1'(rand_bits(1)), 22'(rand_bits(22)), 1'(rand_bits(1)), strobes);
			while (ans_cnt != i + 1)
				@(negedge clk32);
			repeat (2) @(negedge clk32);
			load_active = 1'b0;
		end
		chk0.end_test("read shaping");

		while (!sys_reset_n)
			@(negedge clk32);
		reset_req = 1'b1;
		repeat (3) @(negedge clk32);
		reset_req = 1'b0;
		measure_release("release after reset_req");
		load_active = 1'b1;
		load_index  = IDX_ROM;
		repeat (3) @(negedge clk32);
		load_active = 1'b0;
		measure_release("release after rom download");
		mem_size_sel = ~mem_size_sel;
		@(negedge clk32);
		measure_release("release after mem_size_sel change");
		chk0.end_test("reset stretching");

		chk0.report();
		if (chk0.err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin : watchdog
		#(WDOG_NS);
		$display("timeout, the run did not finish within %0d ns", WDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

/* bench/mem_path_checker.sv */
// samples dut outputs on the falling edge; expectations must be queued before the event appears
`timescale 1ns/100ps

module mem_path_checker
	import mem_path_pkg::*;
(
	input logic        clk32,
	input logic        rst_n,
	input slot_e       slot,
	input logic        load_ready,
	input logic        mem_req,
	input logic [24:0] mem_addr,
	input logic        mem_we,
	input logic [1:0]  mem_be,
	input logic [15:0] mem_wdata,
	input logic        rd_valid,
	input logic [15:0] rd_data,
	input logic [1:0]  disk_inserted,
	input logic [1:0]  disk_double_sided
);

	localparam int BUS_CYC = SLOT_LEN * SLOTS_PER_CYCLE;

	logic [24:0] exp_addr_q [$];
	logic        exp_we_q   [$];
	logic [1:0]  exp_be_q   [$];
	logic [15:0] exp_data_q [$];
	logic [15:0] exp_rd_q   [$];
	logic        ready_d;             // load_ready at the previous falling edge
	int err_cnt      = 0;
	int test_err     = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int cycle        = 0;
	int last_wr      = -100;   // cycle of the previous write

	task automatic fail_value(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		err_cnt++;
		test_err++;
	endtask

	task automatic fail_plain(input string msg);
		$display("%s (at %0t ns)", msg, $time);
		err_cnt++;
		test_err++;
	endtask

	task automatic expect_request(input logic [24:0] a, input logic w, input logic [1:0] be,
		input logic [15:0] d);
		exp_addr_q.push_back(a);
		exp_we_q.push_back(w);
		exp_be_q.push_back(be);
		exp_data_q.push_back(d);
	endtask

	task automatic expect_read(input logic [15:0] d);
		exp_rd_q.push_back(d);
	endtask

	task automatic check_value(input string what, input int got, input int exp);
		if (got != exp)
			fail_value($sformatf("%s took %0d cycles, expected %0d", what, got, exp));
	endtask

	task automatic check_disk(input logic [1:0] ins, input logic [1:0] ds);
		if (disk_inserted !== ins || disk_double_sided !== ds)
			fail_value($sformatf("disk flags ins %b ds %b, expected ins %b ds %b",
				disk_inserted, disk_double_sided, ins, ds));
	endtask

	// ------------------------------
	// request port
	// ------------------------------
	task automatic check_request();
		logic [24:0] a;
		logic        w;
		logic [1:0]  be;
		logic [15:0] d;
		if (exp_addr_q.size() == 0) begin
			fail_plain("sdram request issued while none was expected");
			return;
		end
		a  = exp_addr_q.pop_front();
		w  = exp_we_q.pop_front();
		be = exp_be_q.pop_front();
		d  = exp_data_q.pop_front();
		if (mem_addr !== a || mem_we !== w || mem_be !== be)
			fail_value($sformatf("request addr %h we %b be %b, expected addr %h we %b be %b",
				mem_addr, mem_we, mem_be, a, w, be));
		if (w && mem_wdata !== d)
			fail_value($sformatf("write data %h, expected %h", mem_wdata, d));
		if (mem_we) begin
			if (slot != SLOT_IO)
				fail_plain("a write was issued outside an io slot");
			if (cycle - last_wr < BUS_CYC)
				fail_plain("two writes were issued inside one bus cycle");
			last_wr = cycle;
		end
	endtask

	always @(negedge clk32) begin : compare
		logic [15:0] exp;
		if (rst_n) begin
			cycle++;
			if (mem_req)
				check_request();
			// load_ready comes back in the cycle the held byte goes out
			if ((load_ready && !ready_d) != (mem_req && mem_we))
				fail_value($sformatf("load_ready went %b to %b, write request %b",
					ready_d, load_ready, mem_req && mem_we));
			if (rd_valid) begin
				if (exp_rd_q.size() == 0) begin
					fail_plain("read data came back with no read outstanding");
				end else begin
					exp = exp_rd_q.pop_front();
					if (rd_data !== exp)
						fail_value($sformatf("rd_data %h, expected %h", rd_data, exp));
				end
			end
		end
		ready_d = load_ready;
	end

	task automatic end_test(input string name);
		if (exp_addr_q.size() != 0 || exp_rd_q.size() != 0)
			fail_plain($sformatf("%0d requests and %0d reads never showed up",
				exp_addr_q.size(), exp_rd_q.size()));
		exp_addr_q.delete();
		exp_we_q.delete();
		exp_be_q.delete();
		exp_data_q.delete();
		exp_rd_q.delete();
		tests_run++;
		if (test_err == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, test_err);
			tests_failed++;
		end
		test_err = 0;
	endtask

	task automatic report();
		$display("%0d tests run, %0d passed, %0d failed, %0d errors in total",
			tests_run, tests_run - tests_failed, tests_failed, err_cnt);
	endtask

endmodule

/* bench/mem_path_assertions.sv */
// bound into sdram_port_mux; slot is registered, so it still shows the issuing slot one cycle later
`timescale 1ns/100ps

module mem_path_assertions
	import mem_path_pkg::*;
(
	input logic  clk32,
	input logic  rst_n,
	input slot_e slot,
	input logic  slot_start,
	input logic  mem_req,
	input logic  mem_we
);

	// requests only leave right after a slot boundary
	req_after_slot_start: assert property (@(posedge clk32) disable iff (!rst_n)
		mem_req |-> $past(slot_start))
		else $error("mem_req without a slot start one cycle earlier");

	write_in_io_slot: assert property (@(posedge clk32) disable iff (!rst_n)
		(mem_req && mem_we) |-> (slot == SLOT_IO))   // loader writes only
		else $error("sdram write outside an io slot");

endmodule

bind sdram_port_mux mem_path_assertions u_assert (
	.clk32      (clk32),
	.rst_n      (rst_n),
	.slot       (slot),
	.slot_start (slot_start),
	.mem_req    (mem_req),
	.mem_we     (mem_we)
);

/* design/mem_path_top.sv */
// chipset requests must be held stable across their cpu slot start; no sdram chip controller here
`timescale 1ns/100ps

module mem_path_top
	import mem_path_pkg::*;
(
	input  logic                    clk32,
	input  logic                    rst_n,
	// loader
	input  logic                    load_active,
	input  logic [4:0]              load_index,
	input  logic [23:0]             load_addr,
	input  logic [7:0]              load_data,
	input  logic                    load_wr,
	output logic                    load_ready,
	// chipset
	input  logic [21:0]             cpu_addr,
	input  logic                    cpu_rom,
	input  logic                    cpu_oe,
	input  logic                    cpu_we,
	input  logic                    cpu_uds,
	input  logic                    cpu_lds,
	input  logic [15:0]             cpu_wdata,
	input  logic                    disk_read,
	output logic                    rd_valid,
	output logic [15:0]             rd_data,
	// sdram request port
	output logic                    mem_req,
	output logic [SDRAM_ADDR_W-1:0] mem_addr,
	output logic                    mem_we,
	output logic [1:0]              mem_be,
	output logic [15:0]             mem_wdata,
	input  logic                    mem_rvalid,
	input  logic [15:0]             mem_rdata,
	// floppy and reset
	input  logic                    reset_req,
	input  logic                    mem_size_sel,
	input  logic [1:0]              disk_eject,
	output logic [1:0]              disk_inserted,
	output logic [1:0]              disk_double_sided,
	output logic                    sys_reset_n
);

	slot_e                  slot;
	logic                   slot_start;
	logic                   dl_pending;
	logic [WORD_ADDR_W-1:0] dl_addr;
	logic                   dl_byte_hi;
	logic [15:0]            dl_data;

	bus_slot_sequencer u_seq (
		.clk32      (clk32),
		.rst_n      (rst_n),
		.slot       (slot),
		.slot_start (slot_start)
	);

	download_writer u_dl_writer (
		.clk32      (clk32),
		.rst_n      (rst_n),
		.load_index (load_index),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_wr    (load_wr),
		.slot       (slot),
		.slot_start (slot_start),
		.load_ready (load_ready),
		.dl_pending (dl_pending),
		.dl_addr    (dl_addr),
		.dl_byte_hi (dl_byte_hi),
		.dl_data    (dl_data)
	);

	disk_image_detect u_disk_detect (
		.clk32             (clk32),
		.rst_n             (rst_n),
		.load_active       (load_active),
		.load_index        (load_index),
		.load_addr         (load_addr),
		.disk_eject        (disk_eject),
		.disk_inserted     (disk_inserted),
		.disk_double_sided (disk_double_sided)
	);

	reset_stretcher u_rst_stretch (
		.clk32        (clk32),
		.rst_n        (rst_n),
		.reset_req    (reset_req),
		.load_active  (load_active),
		.load_index   (load_index),
		.mem_size_sel (mem_size_sel),
		.sys_reset_n  (sys_reset_n)
	);

	sdram_port_mux u_port_mux (
		.clk32       (clk32),
		.rst_n       (rst_n),
		.slot        (slot),
		.slot_start  (slot_start),
		.dl_pending  (dl_pending),
		.dl_addr     (dl_addr),
		.dl_byte_hi  (dl_byte_hi),
		.dl_data     (dl_data),
		.load_active (load_active),
		.cpu_addr    (cpu_addr),
		.cpu_rom     (cpu_rom),
		.cpu_oe      (cpu_oe),
		.cpu_we      (cpu_we),
		.cpu_uds     (cpu_uds),
		.cpu_lds     (cpu_lds),
		.cpu_wdata   (cpu_wdata),
		.disk_read   (disk_read),
		.mem_rvalid  (mem_rvalid),
		.mem_rdata   (mem_rdata),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_we      (mem_we),
		.mem_be      (mem_be),
		.mem_wdata   (mem_wdata),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data)
	);

endmodule

/* memory/sdram_port_mux.sv */
// sdram returns reads in order, at most RD_QUEUE_DEPTH in flight; video slot issues nothing
`timescale 1ns/100ps

module sdram_port_mux
	import mem_path_pkg::*;
(
	input  logic                    clk32,
	input  logic                    rst_n,
	input  slot_e                   slot,
	input  logic                    slot_start,
	input  logic                    dl_pending,
	input  logic [WORD_ADDR_W-1:0]  dl_addr,
	input  logic                    dl_byte_hi,
	input  logic [15:0]             dl_data,
	input  logic                    load_active,
	input  logic [21:0]             cpu_addr,
	input  logic                    cpu_rom,
	input  logic                    cpu_oe,
	input  logic                    cpu_we,
	input  logic                    cpu_uds,
	input  logic                    cpu_lds,
	input  logic [15:0]             cpu_wdata,
	input  logic                    disk_read,
	input  logic                    mem_rvalid,
	input  logic [15:0]             mem_rdata,
	output logic                    mem_req,
	output logic [SDRAM_ADDR_W-1:0] mem_addr,
	output logic                    mem_we,
	output logic [1:0]              mem_be,
	output logic [15:0]             mem_wdata,
	output logic                    rd_valid,
	output logic [15:0]             rd_data
);

	logic                    io_issue;
	logic                    cpu_issue;
	logic                    cpu_rd_issue;
	logic [SDRAM_ADDR_W-1:0] cpu_mem_addr;
	logic [1:0]              rd_flags [RD_QUEUE_DEPTH];   // {disk, odd byte}
	logic [RD_PTR_W-1:0]     wr_ptr;
	logic [RD_PTR_W-1:0]     rd_ptr;
	logic [1:0]              head_flags;
	rd_word_u                raw;
	logic [15:0]             shaped;

	assign io_issue  = slot_start && (slot == SLOT_IO) && dl_pending;
	assign cpu_issue = slot_start && ((slot == SLOT_CPU_A) || (slot == SLOT_CPU_B)) &&
		(cpu_oe || cpu_we);
	assign cpu_rd_issue = cpu_issue && !cpu_we;

	always_comb begin
		cpu_mem_addr                    = '0;
		cpu_mem_addr[WORD_ADDR_W-1:0]   = cpu_addr[21:1];
		cpu_mem_addr[ROM_REGION_BIT]    = cpu_rom;   // rom lives above ram
	end

	// ------------------------------
	// request port
	// ------------------------------
	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			mem_req   <= 1'b0;
			mem_addr  <= '0;
			mem_we    <= 1'b0;
			mem_be    <= '0;
			mem_wdata <= '0;
		end else begin
			mem_req <= io_issue || cpu_issue;   // one cycle pulse
			if (io_issue) begin
				mem_addr  <= {DL_REGION_BIT, dl_addr};
				mem_we    <= 1'b1;
				mem_be    <= {dl_byte_hi, ~dl_byte_hi};
				mem_wdata <= dl_data;
			end else if (cpu_issue) begin
				mem_addr  <= cpu_mem_addr;
				mem_we    <= cpu_we;
				mem_be    <= {cpu_uds, cpu_lds};
				mem_wdata <= cpu_wdata;
			end
		end
	end

	// ------------------------------
	// read flags, in order
	// ------------------------------
	always_ff @(posedge clk32) begin
		if (cpu_rd_issue)
			rd_flags[wr_ptr] <= {disk_read, cpu_addr[0]};
	end

	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (cpu_rd_issue)
				wr_ptr <= wr_ptr + RD_PTR_W'(1);   // wraps, depth is a power of two
			if (mem_rvalid)
				rd_ptr <= rd_ptr + RD_PTR_W'(1);
		end
	end

	assign head_flags = rd_flags[rd_ptr];
	assign raw.word   = mem_rdata;

	// black screen during download, byte demux for floppy reads
	always_comb begin
		if (load_active)
			shaped = '1;
		else if (head_flags[1])
			shaped = head_flags[0] ? {raw.bytes[0], raw.bytes[0]} : {raw.bytes[1], raw.bytes[1]};
		else
			shaped = raw.word;
	end

	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			rd_data  <= '0;
		end else begin
			rd_valid <= mem_rvalid;
			if (mem_rvalid)
				rd_data <= shaped;
		end
	end

endmodule

/* download/disk_image_detect.sv */
// only exact double or single sided sizes are recognized; any other size leaves the drive empty
`timescale 1ns/100ps

module disk_image_detect
	import mem_path_pkg::*;
(
	input  logic        clk32,
	input  logic        rst_n,
	input  logic        load_active,
	input  logic [4:0]  load_index,
	input  logic [23:0] load_addr,
	input  logic [1:0]  disk_eject,
	output logic [1:0]  disk_inserted,
	output logic [1:0]  disk_double_sided
);

	logic        load_active_d;
	logic        dl_end;
	logic [22:0] last_word;   // byte address of last byte, in words
	logic [1:0]  img_ds;
	logic [1:0]  img_ss;

	assign dl_end    = load_active_d && !load_active;
	assign last_word = load_addr[23:1];

	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			load_active_d <= 1'b0;
			img_ds        <= '0;
			img_ss        <= '0;
		end else begin
			load_active_d <= load_active;
			for (int i = 0; i < 2; i++) begin
				if (disk_eject[i]) begin   // eject wins over a fresh image
					img_ds[i] <= 1'b0;
					img_ss[i] <= 1'b0;
				end else if (dl_end && (load_index == ((i == 0) ? IDX_DISK0 : IDX_DISK1))) begin
					img_ds[i] <= (last_word == 23'(DISK_DS_LAST_WORD));
					img_ss[i] <= (last_word == 23'(DISK_SS_LAST_WORD));
				end
			end
		end
	end

	// known image type in the drive
	assign disk_inserted     = img_ds | img_ss;
	assign disk_double_sided = img_ds;

endmodule

/* download/download_writer.sv */
// loader may pulse load_wr only while load_ready is high; one byte per bus cycle, no queue
`timescale 1ns/100ps

module download_writer
	import mem_path_pkg::*;
(
	input  logic                   clk32,
	input  logic                   rst_n,
	input  logic [4:0]             load_index,
	input  logic [23:0]            load_addr,
	input  logic [7:0]             load_data,
	input  logic                   load_wr,
	input  slot_e                  slot,
	input  logic                   slot_start,
	output logic                   load_ready,
	output logic                   dl_pending,
	output logic [WORD_ADDR_W-1:0] dl_addr,
	output logic                   dl_byte_hi,
	output logic [15:0]            dl_data
);

	logic [WORD_ADDR_W-1:0] img_offset;
	logic [WORD_ADDR_W-1:0] word_addr;
	logic                   io_start;

	// ------------------------------
	// image index to word address
	// ------------------------------
	always_comb begin
		case (load_index)
			IDX_DISK0: img_offset = IMG_OFFSET_DISK0;   // first floppy at 512k words
			IDX_DISK1: img_offset = IMG_OFFSET_DISK1;   // second floppy at 1M words
			default:   img_offset = '0;                 // os rom
		endcase
	end

	// loader counts bytes, sdram counts words
	assign word_addr = load_addr[WORD_ADDR_W:1] + img_offset;

	assign io_start = slot_start && (slot == SLOT_IO);

	// ------------------------------
	// handshake
	// ------------------------------
	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			load_ready <= 1'b1;
			dl_pending <= 1'b0;
		end else begin
			if (load_wr) begin
				load_ready <= 1'b0;   // held until the io slot takes it
				dl_pending <= 1'b1;
			end else if (io_start && dl_pending) begin
				dl_pending <= 1'b0;   // mux issues the write now
				load_ready <= 1'b1;
			end
		end
	end

	// byte latch, same byte on both lanes
	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			dl_addr    <= '0;
			dl_byte_hi <= 1'b0;
			dl_data    <= '0;
		end else if (load_wr) begin
			dl_addr    <= word_addr;
			dl_byte_hi <= ~load_addr[0];   // even byte goes high (big endian)
			dl_data    <= {load_data, load_data};
		end
	end

endmodule

/* design/reset_stretcher.sv */
// mem_size_sel must be synchronous to clk32; any change of it counts as a reset source
`timescale 1ns/100ps

module reset_stretcher
	import mem_path_pkg::*;
(
	input  logic       clk32,
	input  logic       rst_n,
	input  logic       reset_req,
	input  logic       load_active,
	input  logic [4:0] load_index,
	input  logic       mem_size_sel,
	output logic       sys_reset_n
);

	logic                   mem_size_d;
	logic                   rom_download;
	logic                   rst_source;
	logic [RESET_CNT_W-1:0] hold_cnt;

	assign rom_download = load_active && (load_index == IDX_ROM);

	// any of these restarts the hold time
	assign rst_source = reset_req || rom_download || (mem_size_sel != mem_size_d);

	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			mem_size_d <= 1'b0;
			hold_cnt   <= RESET_CNT_W'(RESET_HOLD - 1);
		end else begin
			mem_size_d <= mem_size_sel;
			// reload to HOLD-1 so release lands exactly RESET_HOLD cycles later
			if (rst_source)
				hold_cnt <= RESET_CNT_W'(RESET_HOLD - 1);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - RESET_CNT_W'(1);
		end
	end

	assign sys_reset_n = (hold_cnt == '0) && !rst_source;

endmodule

/* design/bus_slot_sequencer.sv */
// free running from reset release, no stall input; first slot after reset is video
`timescale 1ns/100ps

module bus_slot_sequencer
	import mem_path_pkg::*;
(
	input  logic  clk32,
	input  logic  rst_n,
	output slot_e slot,
	output logic  slot_start
);

	// ------------------------------
	// video | cpu_a | io | cpu_b
	// ------------------------------
	logic [SLOT_CNT_W-1:0] cyc_cnt;    // clk32 cycle inside the slot
	logic [1:0]            slot_cnt;

	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			cyc_cnt  <= '0;
			slot_cnt <= '0;   // video first
		end else begin
			if (cyc_cnt == SLOT_CNT_W'(SLOT_LEN - 1)) begin
				cyc_cnt <= '0;
				if (slot_cnt == 2'(SLOTS_PER_CYCLE - 1))
					slot_cnt <= '0;
				else
					slot_cnt <= slot_cnt + 2'd1;
			end else begin
				cyc_cnt <= cyc_cnt + SLOT_CNT_W'(1);
			end
		end
	end

	assign slot       = slot_e'(slot_cnt);
	assign slot_start = (cyc_cnt == '0);   // first cycle of each slot

endmodule

/* common/mem_path_pkg.sv */
// word addresses count 16-bit words; queue depth and counter widths assume powers of two
package mem_path_pkg;

	// ------------------------------
	// bus cycle timing
	// ------------------------------
	localparam int SLOT_LEN        = 4;                  // clk32 cycles per slot
	localparam int SLOTS_PER_CYCLE = 4;
	localparam int SLOT_CNT_W      = $clog2(SLOT_LEN);

	typedef enum logic [1:0] {
		SLOT_VIDEO = 2'd0,
		SLOT_CPU_A = 2'd1,
		SLOT_IO    = 2'd2,   // loader writes only
		SLOT_CPU_B = 2'd3
	} slot_e;

	// ------------------------------
	// sdram address map
	// ------------------------------
	localparam int WORD_ADDR_W  = 21;   // word address inside the bank
	localparam int SDRAM_ADDR_W = 25;

	// disk images sit right after the os rom
	localparam logic [WORD_ADDR_W-1:0] IMG_OFFSET_DISK0 = 21'h80000;
	localparam logic [WORD_ADDR_W-1:0] IMG_OFFSET_DISK1 = 21'h100000;

	localparam logic [3:0] DL_REGION_BIT  = 4'b0001;   // prefix above dl word address
	localparam int         ROM_REGION_BIT = 21;        // set for rom accesses

	// floppy images, 819200 and 409600 bytes
	localparam int DISK_DS_LAST_WORD = 409599;
	localparam int DISK_SS_LAST_WORD = 204799;

	localparam int RESET_HOLD  = 1024;   // clk32 cycles
	localparam int RESET_CNT_W = $clog2(RESET_HOLD);

	localparam int RD_QUEUE_DEPTH = 4;   // reads in flight
	localparam int RD_PTR_W       = $clog2(RD_QUEUE_DEPTH);

	// image index codes from the loader
	localparam logic [4:0] IDX_ROM   = 5'd0;
	localparam logic [4:0] IDX_DISK0 = 5'd1;
	localparam logic [4:0] IDX_DISK1 = 5'd2;

	// one sdram read word, or its two bytes for disk reads
	typedef union packed {
		logic [15:0]     word;
		logic [1:0][7:0] bytes;   // [1] is the high byte
	} rd_word_u;

endpackage
